/* source/factBusPkg.sv */
package factBusPkg;

    //////////////////////////////
    // bus widths
    //////////////////////////////
    localparam int ADDR_W  = 2;
    localparam int WDATA_W = 4;
    localparam int RDATA_W = 32;

    typedef logic [ADDR_W-1:0]  addrT;
    typedef logic [WDATA_W-1:0] wdataT;
    typedef logic [RDATA_W-1:0] rdataT;

    //////////////////////////////
    // register map
    //////////////////////////////
    localparam addrT ADDR_N      = 2'd0; // operand, zero-extended on read
    localparam addrT ADDR_GO     = 2'd1; // write bit 0 to start, read busy
    localparam addrT ADDR_STATUS = 2'd2; // bit 0 done, bit 1 error
    localparam addrT ADDR_RESULT = 2'd3;

    // one host access, sampled at the clock edge
    typedef struct packed {
        addrT  addr;
        logic  we;
        wdataT wdata;
    } busReqT;

endpackage

/* source/factCorePkg.sv */
package factCorePkg;

    //////////////////////////////
    // operand and product
    //////////////////////////////
    localparam int OPERAND_W = 4;
    localparam int PRODUCT_W = 32;

    typedef logic [OPERAND_W-1:0] operandT;
    typedef logic [PRODUCT_W-1:0] productT;

    // 13! overflows 32 bits
    localparam operandT MAX_N = 4'd12;

    //////////////////////////////
    // controller
    //////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        CHECK,
        RUN,
        FINISH,
        FAIL
    } ctrlStateT;

    // per-cycle commands to counter and datapath
    typedef struct packed {
        logic countLoad;
        logic countDec;
        logic productInit;
        logic productMul;
    } ctrlT;

    // controller report to the register block
    typedef struct packed {
        logic finish; // last cycle of a good run
        logic fail;   // operand out of range
        logic busy;
    } statusT;

    localparam ctrlT   CTRL_NONE   = '0;
    localparam statusT STATUS_NONE = '0;

endpackage

/* source/factCounter.sv */
`timescale 1ns/100ps

module factCounter (
    input  logic                 CLK,
    input  logic                 RST,
    input  factCorePkg::ctrlT    ctrl,
    input  factCorePkg::operandT operand,
    output factCorePkg::operandT count,
    output logic                 countGtOne
);

    import factCorePkg::*;

    operandT nextCount;

    always_comb begin
        nextCount = count;
        if (ctrl.countLoad) begin
            nextCount = operand;
        end else if (ctrl.countDec) begin
            nextCount = count - operandT'(1);
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            count <= '0;
        end else begin
            count <= nextCount;
        end
    end

    // loop test on the value after this cycle's step
    assign countGtOne = (nextCount > operandT'(1));

endmodule

/* source/factDatapath.sv */
`timescale 1ns/100ps

module factDatapath (
    input  logic                 CLK,
    input  logic                 RST,
    input  factCorePkg::ctrlT    ctrl,
    input  factCorePkg::operandT count,
    output factCorePkg::productT product
);

    import factCorePkg::*;

    productT mulOut;
    productT nextProduct;

    //////////////////////////////
    // multiplier
    //////////////////////////////
    // never overflows for n up to MAX_N
    assign mulOut = product * productT'(count);

    always_comb begin
        nextProduct = product;
        if (ctrl.productInit) begin
            nextProduct = productT'(1);
        end else if (ctrl.productMul) begin
            nextProduct = mulOut;
        end
    end

    //////////////////////////////
    // product register
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            product <= '0;
        end else begin
            product <= nextProduct;
        end
    end

endmodule

/* source/factCtrl.sv */
`timescale 1ns/100ps

module factCtrl (
    input  logic                 CLK,
    input  logic                 RST,
    input  logic                 start,
    input  factCorePkg::operandT operand,
    input  logic                 countGtOne,
    output factCorePkg::ctrlT    ctrl,
    output factCorePkg::statusT  status
);

    import factCorePkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      operandBad;

    assign operandBad = (operand > MAX_N);

    //////////////////////////////
    // state register
    //////////////////////////////
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        nextState = state;
        unique case (state)
            IDLE: begin
                if (start) begin
                    nextState = LOAD;
                end
            end
            LOAD: begin
                nextState = CHECK;
            end
            CHECK: begin
                if (operandBad) begin
                    nextState = FAIL;
                end else if (countGtOne) begin
                    nextState = RUN;
                end else begin
                    nextState = FINISH; // 0! and 1!
                end
            end
            RUN: begin
                // countGtOne looks at the counter after this step
                if (!countGtOne) begin
                    nextState = FINISH;
                end
            end
            FINISH: begin
                nextState = IDLE;
            end
            FAIL: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    //////////////////////////////
    // output decode
    //////////////////////////////
    always_comb begin
        ctrl        = CTRL_NONE;
        status      = STATUS_NONE;
        status.busy = (state != IDLE);
        unique case (state)
            IDLE: begin
                status.busy = 1'b0;
            end
            LOAD: begin
                ctrl.countLoad   = 1'b1;
                ctrl.productInit = 1'b1;
            end
            CHECK: begin
                ctrl = CTRL_NONE; // decide only
            end
            RUN: begin
                ctrl.countDec   = 1'b1;
                ctrl.productMul = 1'b1;
            end
            FINISH: begin
                status.finish = 1'b1;
            end
            FAIL: begin
                status.fail = 1'b1;
            end
            default: begin
                ctrl   = CTRL_NONE;
                status = STATUS_NONE;
            end
        endcase
    end

endmodule

/* source/factRegs.sv */
`timescale 1ns/100ps

module factRegs (
    input  logic                CLK,
    input  logic                RST,
    input  factBusPkg::busReqT  busReq,
    input  factCorePkg::statusT status,
    input  factCorePkg::productT product,
    output factCorePkg::operandT operand,
    output logic                start,
    output factBusPkg::rdataT   rdata
);

    import factBusPkg::*;
    import factCorePkg::*;

    logic    nWrite;
    logic    goWrite;
    logic    done;
    logic    error;
    productT result;

    //////////////////////////////
    // address decode
    //////////////////////////////
    assign nWrite  = busReq.we && (busReq.addr == ADDR_N);
    assign goWrite = busReq.we && (busReq.addr == ADDR_GO);

    // operand register
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            operand <= '0;
        end else if (nWrite) begin
            operand <= busReq.wdata[OPERAND_W-1:0];
        end
    end

    // go write becomes a one-cycle start pulse
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start <= 1'b0;
        end else begin
            start <= goWrite && busReq.wdata[0];
        end
    end

    //////////////////////////////
    // status flags
    //////////////////////////////
    // set wins, a start seen in FINISH is dropped by the FSM
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else if (status.finish || status.fail) begin
            done  <= 1'b1;
            error <= status.fail;
        end else if (start) begin
            done  <= 1'b0;
            error <= 1'b0;
        end
    end

    // result capture
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            result <= '0;
        end else if (status.fail) begin
            result <= '0;
        end else if (status.finish) begin
            result <= product;
        end
    end

    //////////////////////////////
    // read mux
    //////////////////////////////
    always_comb begin
        rdata = '0;
        unique case (busReq.addr)
            ADDR_N:      rdata = rdataT'(operand);
            ADDR_GO:     rdata = rdataT'(status.busy);
            ADDR_STATUS: rdata = rdataT'({error, done});
            ADDR_RESULT: rdata = rdataT'(result);
            default:     rdata = '0;
        endcase
    end

endmodule

/* source/factTop.sv */
`timescale 1ns/100ps

module factTop (
    input  logic              CLK,
    input  logic              RST,
    input  factBusPkg::addrT  addr,
    input  logic              we,
    input  factBusPkg::wdataT wdata,
    output factBusPkg::rdataT rdata
);

    import factBusPkg::*;
    import factCorePkg::*;

    busReqT  busReq;
    operandT operand;
    logic    start;
    ctrlT    ctrl;
    statusT  status;
    operandT count;
    logic    countGtOne;
    productT product;

    assign busReq = '{addr: addr, we: we, wdata: wdata};

    //////////////////////////////
    // host side
    //////////////////////////////
    factRegs u_factRegs (
        .CLK     (CLK),
        .RST     (RST),
        .busReq  (busReq),
        .status  (status),
        .product (product),
        .operand (operand),
        .start   (start),
        .rdata   (rdata)
    );

    //////////////////////////////
    // accelerator core
    //////////////////////////////
    factCtrl u_factCtrl (
        .CLK        (CLK),
        .RST        (RST),
        .start      (start),
        .operand    (operand),
        .countGtOne (countGtOne),
        .ctrl       (ctrl),
        .status     (status)
    );

    factCounter u_factCounter (
        .CLK        (CLK),
        .RST        (RST),
        .ctrl       (ctrl),
        .operand    (operand),
        .count      (count),
        .countGtOne (countGtOne)
    );

    factDatapath u_factDatapath (
        .CLK     (CLK),
        .RST     (RST),
        .ctrl    (ctrl),
        .count   (count),
        .product (product)
    );

endmodule

/* dv/factTb.sv */
`timescale 1ns/100ps

module factTb;

    import factBusPkg::*;
    import factCorePkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 21; // computations plus register checks
    localparam int CYCLES_PER_TEST = 40;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
    localparam int POLL_LIMIT      = 30;

    logic   CLK;
    logic   RST;
    addrT   addr;
    logic   we;
    wdataT  wdata;
    rdataT  rdata;
    integer seed;

    factTop u_factTop (
        .CLK   (CLK),
        .RST   (RST),
        .addr  (addr),
        .we    (we),
        .wdata (wdata),
        .rdata (rdata)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    //////////////////////////////
    // bus access
    //////////////////////////////
    task automatic writeReg(input addrT a, input wdataT d);
        @(negedge CLK);
        addr  = a;
        we    = 1'b1;
        wdata = d;
        @(negedge CLK);
        we    = 1'b0;
        wdata = '0;
    endtask

    // read data is combinational, sampled well before the next rising edge
    task automatic readReg(input addrT a, output rdataT d);
        @(negedge CLK);
        addr = a;
        we   = 1'b0;
        #1;
        d = rdata;
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////
    task automatic expectEqual(input string name, input rdataT expected, input rdataT actual);
        valueMatch: assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "register value check failed");
        end
    endtask

    task automatic checkReg(input addrT a, input rdataT expected, input string name);
        rdataT value;
        readReg(a, value);
        expectEqual(name, expected, value);
    endtask

    // no register but the result uses more than 4 bits
    upperBitsZero: assert property (
        @(posedge CLK) disable iff (!RST)
        (addr != ADDR_RESULT) |-> (rdata[31:4] == '0)
    ) else begin
        $display("MISMATCH time=%0t signal=rdata[31:4] expected=0 actual=%h",
            $time, $sampled(rdata[31:4]));
        $display("TEST RESULT: FAIL");
        $fatal(1, "upper read data bits not zero");
    end

    // error never shows without done
    errorNeedsDone: assert property (
        @(posedge CLK) disable iff (!RST)
        (addr == ADDR_STATUS) |-> !(rdata[1] && !rdata[0])
    ) else begin
        $display("MISMATCH time=%0t signal=status expected=done with error actual=%h",
            $time, $sampled(rdata[1:0]));
        $display("TEST RESULT: FAIL");
        $fatal(1, "error bit set while done is low");
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic rdataT refFactorial(input int n);
        rdataT acc;
        acc = 32'd1;
        if (n > int'(MAX_N)) begin
            return '0; // rejected operand
        end
        for (int i = 2; i <= n; i++) begin
            acc = acc * rdataT'(i);
        end
        return acc;
    endfunction

    task automatic waitDone(output rdataT statusWord);
        int polls;
        polls = 0;
        readReg(ADDR_STATUS, statusWord);
        while (statusWord[0] !== 1'b1) begin
            polls++;
            if (polls >= POLL_LIMIT) begin
                $display("done never rose within %0d status reads, time %0t",
                    POLL_LIMIT, $time);
                $display("TEST RESULT: FAIL");
                $fatal(1, "done bit timeout");
            end
            readReg(ADDR_STATUS, statusWord);
        end
    endtask

    // start on the operand already in the register
    task automatic startAndCheck(input int n);
        rdataT statusWord;
        logic  expectError;
        expectError = (n > int'(MAX_N));
        writeReg(ADDR_GO, 4'h1);
        waitDone(statusWord);
        expectEqual("status", {30'd0, expectError, 1'b1}, statusWord);
        checkReg(ADDR_RESULT, refFactorial(n), "result");
    endtask

    task automatic runFactorial(input int n);
        writeReg(ADDR_N, wdataT'(n));
        startAndCheck(n);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin : stimulus
        int n;
        CLK   = 1'b0;
        RST   = 1'b0;
        addr  = '0;
        we    = 1'b0;
        wdata = '0;
        seed  = 32'h0c36_f989;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;

        // everything reads zero out of reset
        checkReg(ADDR_N, '0, "operand");
        checkReg(ADDR_GO, '0, "busy");
        checkReg(ADDR_STATUS, '0, "status");
        checkReg(ADDR_RESULT, '0, "result");

        // operand readback, other writes leave it alone
        writeReg(ADDR_N, 4'hA);
        checkReg(ADDR_N, 32'h0000_000A, "operand");
        writeReg(ADDR_STATUS, 4'h3);
        writeReg(ADDR_RESULT, 4'h5);
        checkReg(ADDR_N, 32'h0000_000A, "operand");
        checkReg(ADDR_STATUS, '0, "status");
        checkReg(ADDR_RESULT, '0, "result");
        writeReg(ADDR_GO, 4'hE); // bit 0 clear, no start
        checkReg(ADDR_GO, '0, "busy");
        checkReg(ADDR_N, 32'h0000_000A, "operand");

        // full legal range
        for (n = 0; n <= int'(MAX_N); n++) begin
            runFactorial(n);
        end

        // out of range operands
        repeat (4) begin
            n = 13 + ($unsigned($random(seed)) % 3);
            runFactorial(n);
        end

        // new start clears the error left by the last run
        writeReg(ADDR_N, 4'd12);
        writeReg(ADDR_GO, 4'h1);
        checkReg(ADDR_STATUS, '0, "status");
        checkReg(ADDR_GO, 32'd1, "busy");

        // counter is loaded by now, so these must not touch the run
        writeReg(ADDR_N, 4'd5);
        writeReg(ADDR_GO, 4'h1);
        checkReg(ADDR_GO, 32'd1, "busy");
        begin : inFlight
            rdataT statusWord;
            waitDone(statusWord);
            expectEqual("status", 32'd1, statusWord);
        end
        checkReg(ADDR_RESULT, refFactorial(12), "result");
        checkReg(ADDR_N, 32'd5, "operand");

        // rewritten operand drives the next run
        startAndCheck(5);

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation did not complete", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* flist.f */
source/factBusPkg.sv
source/factCorePkg.sv
source/factCounter.sv
source/factDatapath.sv
source/factCtrl.sv
source/factRegs.sv
source/factTop.sv
dv/factTb.sv

/* run.sh */
#!/bin/sh
# builds the factorial accelerator testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module factTb \
    -f flist.f \
    -o factSim &&
./obj_dir/factSim &&
echo "simulation finished cleanly" ||
{ echo "simulation build or run failed"; exit 1; }
